/* filelist.f */
logic/rx_pkg.sv
logic/rx_frame_fifo.sv
logic/rx_frame_arbiter.sv
logic/rx_fifo.sv
test/rx_clock_gen.sv
test/rx_fifo_tb.sv

/* logic/rx_fifo.sv */
// Two-port receive FIFO, one frame FIFO per port merged by a round-robin arbiter
`timescale 1ns/1ps

module rx_fifo import rx_pkg::*; (
    input  logic                              clk,
    input  logic                              reset,

    // Port input streams
    input  logic [ports-1:0][data_width-1:0]  s_axis_tdata,
    input  logic [ports-1:0]                  s_axis_tvalid,
    output logic [ports-1:0]                  s_axis_tready,
    input  logic [ports-1:0]                  s_axis_tlast,
    input  logic [ports-1:0]                  s_axis_tuser,

    // Merged output stream
    output logic [data_width-1:0]             m_axis_tdata,
    output logic                              m_axis_tvalid,
    input  logic                              m_axis_tready,
    output logic                              m_axis_tlast,
    output logic [port_id_width-1:0]          m_axis_tid,

    // Per-port status
    output logic [ports-1:0][depth_width-1:0] status_depth,
    output logic [ports-1:0][depth_width-1:0] status_depth_commit,
    output logic [ports-1:0]                  status_overflow,
    output logic [ports-1:0]                  status_bad_frame,
    output logic [ports-1:0]                  status_good_frame
);

    // FIFO outputs toward the arbiter
    logic [ports-1:0][data_width-1:0] fifo_data;
    logic [ports-1:0]                 fifo_valid;
    logic [ports-1:0]                 fifo_ready;
    logic [ports-1:0]                 fifo_last;

    rx_frame_fifo fifo_0 (
        .clk                 (clk),
        .reset               (reset),
        .s_data              (s_axis_tdata[0]),
        .s_valid             (s_axis_tvalid[0]),
        .s_ready             (s_axis_tready[0]),
        .s_last              (s_axis_tlast[0]),
        .s_user              (s_axis_tuser[0]),
        .m_data              (fifo_data[0]),
        .m_valid             (fifo_valid[0]),
        .m_ready             (fifo_ready[0]),
        .m_last              (fifo_last[0]),
        .status_depth        (status_depth[0]),
        .status_depth_commit (status_depth_commit[0]),
        .status_overflow     (status_overflow[0]),
        .status_bad_frame    (status_bad_frame[0]),
        .status_good_frame   (status_good_frame[0])
    );

    rx_frame_fifo fifo_1 (
        .clk                 (clk),
        .reset               (reset),
        .s_data              (s_axis_tdata[1]),
        .s_valid             (s_axis_tvalid[1]),
        .s_ready             (s_axis_tready[1]),
        .s_last              (s_axis_tlast[1]),
        .s_user              (s_axis_tuser[1]),
        .m_data              (fifo_data[1]),
        .m_valid             (fifo_valid[1]),
        .m_ready             (fifo_ready[1]),
        .m_last              (fifo_last[1]),
        .status_depth        (status_depth[1]),
        .status_depth_commit (status_depth_commit[1]),
        .status_overflow     (status_overflow[1]),
        .status_bad_frame    (status_bad_frame[1]),
        .status_good_frame   (status_good_frame[1])
    );

    rx_frame_arbiter arb_i (
        .clk     (clk),
        .reset   (reset),
        .s_data  (fifo_data),
        .s_valid (fifo_valid),
        .s_ready (fifo_ready),
        .s_last  (fifo_last),
        .m_data  (m_axis_tdata),
        .m_valid (m_axis_tvalid),
        .m_ready (m_axis_tready),
        .m_last  (m_axis_tlast),
        .m_id    (m_axis_tid)
    );

endmodule

/* logic/rx_frame_arbiter.sv */
// Round-robin frame arbiter that merges the port streams and tags each frame with its port
`timescale 1ns/1ps

module rx_frame_arbiter import rx_pkg::*; (
    input  logic                                 clk,
    input  logic                                 reset,

    // Frame streams from the port FIFOs
    input  logic [ports-1:0][data_width-1:0]     s_data,
    input  logic [ports-1:0]                     s_valid,
    output logic [ports-1:0]                     s_ready,
    input  logic [ports-1:0]                     s_last,

    // Merged output stream
    output logic [data_width-1:0]                m_data,
    output logic                                 m_valid,
    input  logic                                 m_ready,
    output logic                                 m_last,
    output logic [port_id_width-1:0]             m_id
);

    arb_state_t               state;

    // Port holding the grant, and the port with first claim next time
    logic [port_id_width-1:0] grant;
    logic [port_id_width-1:0] rr_ptr;

    logic                     req_found;
    logic [port_id_width-1:0] req_port;
    logic [port_id_width-1:0] cand;

    // Search for a requester starting at the round-robin pointer
    always_comb begin
        req_found = 1'b0;
        req_port  = rr_ptr;
        cand      = rr_ptr;
        for (int i = 0; i < ports; i++) begin
            cand = port_id_width'((int'(rr_ptr) + i) % ports);
            if (!req_found && s_valid[cand]) begin
                req_found = 1'b1;
                req_port  = cand;
            end
        end
    end

    // Granted input goes straight through
    assign m_data  = s_data[grant];
    assign m_last  = s_last[grant];
    assign m_valid = (state == arb_frame) && s_valid[grant];
    assign m_id    = grant;

    always_comb begin
        s_ready = '0;
        if (state == arb_frame) begin
            s_ready[grant] = m_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= arb_idle;
            grant  <= '0;
            rr_ptr <= '0;
        end else begin
            case (state)
                arb_idle: begin
                    if (req_found) begin
                        grant <= req_port;
                        state <= arb_frame;
                    end
                end
                arb_frame: begin
                    // Hold the grant until the frame's last beat leaves
                    if (m_valid && m_ready && m_last) begin
                        rr_ptr <= port_id_width'((int'(grant) + 1) % ports);
                        state  <= arb_idle;
                    end
                end
                default: state <= arb_idle;
            endcase
        end
    end

endmodule

/* logic/rx_frame_fifo.sv */
// Store-and-forward frame FIFO that drops bad and oversize frames and reports status
`timescale 1ns/1ps

module rx_frame_fifo import rx_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,

    // Input stream
    input  logic [data_width-1:0]  s_data,
    input  logic                   s_valid,
    output logic                   s_ready,
    input  logic                   s_last,
    input  logic                   s_user,

    // Output stream
    output logic [data_width-1:0]  m_data,
    output logic                   m_valid,
    input  logic                   m_ready,
    output logic                   m_last,

    // Status
    output logic [depth_width-1:0] status_depth,
    output logic [depth_width-1:0] status_depth_commit,
    output logic                   status_overflow,
    output logic                   status_bad_frame,
    output logic                   status_good_frame
);

    // Frame storage with data and last flag per word
    logic [data_width-1:0]  mem_data [fifo_depth];
    logic                   mem_last [fifo_depth];

    // Pointers carry one wrap bit above the RAM address
    logic [depth_width-1:0] wr_ptr;
    logic [depth_width-1:0] wr_ptr_commit;
    logic [depth_width-1:0] rd_ptr;
    logic [depth_width-1:0] wr_ptr_next;

    // Current frame is being thrown away
    logic                   drop_frame;

    logic                   full;
    logic                   empty;
    logic                   wr_beat;
    logic                   out_load;

    assign wr_ptr_next = wr_ptr + 1'b1;

    // Full compares against the read pointer, so committed and pending words both count
    assign full = (wr_ptr == {~rd_ptr[fifo_addr_width], rd_ptr[fifo_addr_width-1:0]});

    // Only committed words are visible to the read side
    assign empty = (rd_ptr == wr_ptr_commit);

    assign s_ready  = !full || drop_frame;
    assign wr_beat  = s_valid && s_ready;
    assign out_load = !empty && (!m_valid || m_ready);

    // Word in the output register still counts as stored
    assign status_depth        = wr_ptr - rd_ptr + depth_width'(m_valid);
    assign status_depth_commit = wr_ptr_commit - rd_ptr + depth_width'(m_valid);

    always_ff @(posedge clk) begin
        if (wr_beat && !drop_frame) begin
            mem_data[wr_ptr[fifo_addr_width-1:0]] <= s_data;
            mem_last[wr_ptr[fifo_addr_width-1:0]] <= s_last;
        end
    end

    // Write side with commit and drop control
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr            <= '0;
            wr_ptr_commit     <= '0;
            drop_frame        <= 1'b0;
            status_overflow   <= 1'b0;
            status_bad_frame  <= 1'b0;
            status_good_frame <= 1'b0;
        end else begin
            status_overflow   <= 1'b0;
            status_bad_frame  <= 1'b0;
            status_good_frame <= 1'b0;

            if (wr_beat) begin
                if (drop_frame) begin
                    // Swallow the rest of an oversize frame
                    if (s_last) begin
                        drop_frame      <= 1'b0;
                        status_overflow <= 1'b1;
                    end
                end else if (s_last) begin
                    if (s_user) begin
                        // Bad frame rewinds to the last good boundary
                        wr_ptr           <= wr_ptr_commit;
                        status_bad_frame <= 1'b1;
                    end else begin
                        wr_ptr            <= wr_ptr_next;
                        wr_ptr_commit     <= wr_ptr_next;
                        status_good_frame <= 1'b1;
                    end
                end else if ((wr_ptr_next - wr_ptr_commit) == depth_width'(fifo_depth)) begin
                    // Frame filled the whole RAM without last
                    wr_ptr     <= wr_ptr_commit;
                    drop_frame <= 1'b1;
                end else begin
                    wr_ptr <= wr_ptr_next;
                end
            end
        end
    end

    // Read side control
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr  <= '0;
            m_valid <= 1'b0;
        end else begin
            if (out_load) begin
                rd_ptr  <= rd_ptr + 1'b1;
                m_valid <= 1'b1;
            end else if (m_ready) begin
                m_valid <= 1'b0;
            end
        end
    end

    // Registered RAM output
    always_ff @(posedge clk) begin
        if (out_load) begin
            m_data <= mem_data[rd_ptr[fifo_addr_width-1:0]];
            m_last <= mem_last[rd_ptr[fifo_addr_width-1:0]];
        end
    end

endmodule

/* logic/rx_pkg.sv */
// Receive path package with shared widths, FIFO sizing and arbiter states

package rx_pkg;

    // Byte-wide streams on both sides
    localparam int data_width = 8;

    // Input ports merged by the arbiter
    localparam int ports = 2;

    // Source port tag carried on tid
    localparam int port_id_width = 1;

    // Words held by each frame FIFO
    localparam int fifo_depth = 32;

    // RAM address width for fifo_depth words
    localparam int fifo_addr_width = 5;

    // Depth counters and pointers need one extra bit for fifo_depth itself
    localparam int depth_width = 6;

    // Arbiter states
    typedef enum logic {
        // Choosing the next port with a frame ready
        arb_idle,
        // Passing the granted frame until its last beat
        arb_frame
    } arb_state_t;

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the receive FIFO testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module rx_fifo_tb \
    -f filelist.f \
    -o rx_fifo_sim

./obj_dir/rx_fifo_sim | tee sim.log

if grep -qx "ALL CHECKS PASSED" sim.log; then
    echo "Simulation result: pass"
else
    echo "Simulation result: fail"
    exit 1
fi

/* test/rx_clock_gen.sv */
// Clock and reset source for the receive FIFO testbench
`timescale 1ns/1ps

module rx_clock_gen (
    output logic clk,
    output logic reset
);

    // 40 ns clock period
    localparam int half_period = 20;
    localparam int reset_cycles = 3;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // Reset drops just after the third rising edge
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

/* test/rx_fifo_tb.sv */
// Table-driven testbench for the two-port receive FIFO with a frame reference model
`timescale 1ns/1ps

module rx_fifo_tb import rx_pkg::*; ();

    localparam int drive_delay = 1;
    localparam int max_rows = 16;
    localparam int num_tests = 5;
    localparam int held_test = 4;
    localparam int parallel_test = 5;

    // Output ready behaviour for a row
    localparam int out_open = 0;
    localparam int out_held = 1;
    localparam int out_random = 2;

    logic                              clk;
    logic                              reset;
    logic [ports-1:0][data_width-1:0]  s_axis_tdata;
    logic [ports-1:0]                  s_axis_tvalid;
    logic [ports-1:0]                  s_axis_tready;
    logic [ports-1:0]                  s_axis_tlast;
    logic [ports-1:0]                  s_axis_tuser;
    logic [data_width-1:0]             m_axis_tdata;
    logic                              m_axis_tvalid;
    logic                              m_axis_tready;
    logic                              m_axis_tlast;
    logic [port_id_width-1:0]          m_axis_tid;
    logic [ports-1:0][depth_width-1:0] status_depth;
    logic [ports-1:0][depth_width-1:0] status_depth_commit;
    logic [ports-1:0]                  status_overflow;
    logic [ports-1:0]                  status_bad_frame;
    logic [ports-1:0]                  status_good_frame;

    // Frame table
    int    row_test [max_rows];
    int    row_port [max_rows];
    int    row_len [max_rows];
    int    row_bad [max_rows];
    int    row_first [max_rows];
    int    row_mode [max_rows];
    int    row_count = 0;
    string test_name [1:num_tests];

    // Reference model of good frames per port in send order
    int                    exp_len [ports][$];
    logic [data_width-1:0] exp_bytes [ports][$];
    int                    exp_order [$];
    int                    tid_order [$];
    int                    exp_good [ports];
    int                    exp_bad [ports];
    int                    exp_ovf [ports];
    int                    good_cnt [ports];
    int                    bad_cnt [ports];
    int                    ovf_cnt [ports];
    int                    held_words [ports];

    // Output frame being collected
    logic   in_frame = 1'b0;
    int     frame_id = 0;
    int     beat_cnt = 0;
    int     cur_len = 0;

    integer seed = 71123;
    int     out_mode = out_open;
    int     errors = 0;
    int     pass_count = 0;
    int     fail_count = 0;
    int     cycles = 0;
    int     timeout_limit = 0;

    rx_clock_gen clk_gen_i (
        .clk   (clk),
        .reset (reset)
    );

    rx_fifo dut_i (
        .clk                 (clk),
        .reset               (reset),
        .s_axis_tdata        (s_axis_tdata),
        .s_axis_tvalid       (s_axis_tvalid),
        .s_axis_tready       (s_axis_tready),
        .s_axis_tlast        (s_axis_tlast),
        .s_axis_tuser        (s_axis_tuser),
        .m_axis_tdata        (m_axis_tdata),
        .m_axis_tvalid       (m_axis_tvalid),
        .m_axis_tready       (m_axis_tready),
        .m_axis_tlast        (m_axis_tlast),
        .m_axis_tid          (m_axis_tid),
        .status_depth        (status_depth),
        .status_depth_commit (status_depth_commit),
        .status_overflow     (status_overflow),
        .status_bad_frame    (status_bad_frame),
        .status_good_frame   (status_good_frame)
    );

    task automatic add_row(input int t, input int p, input int len, input int bad,
                           input int first, input int mode);
        row_test[row_count]  = t;
        row_port[row_count]  = p;
        row_len[row_count]   = len;
        row_bad[row_count]   = bad;
        row_first[row_count] = first;
        row_mode[row_count]  = mode;
        row_count++;
    endtask

    // Drive one frame beat by beat and sample ready at the falling edge
    task automatic send_frame(input int r);
        int   p;
        int   n;
        logic rdy;
        logic ready_low;
        p = row_port[r];
        n = 0;
        ready_low = 1'b0;
        if (row_bad[r] != 0) begin
            exp_bad[p]++;
        end else if (row_len[r] > fifo_depth) begin
            exp_ovf[p]++;
        end else begin
            exp_good[p]++;
            exp_len[p].push_back(row_len[r]);
            for (int i = 0; i < row_len[r]; i++)
                exp_bytes[p].push_back(data_width'(row_first[r] + i));
            exp_order.push_back(p);
            held_words[p] += row_len[r];
        end
        while (n < row_len[r]) begin
            s_axis_tvalid[p] = 1'b1;
            s_axis_tdata[p]  = data_width'(row_first[r] + n);
            s_axis_tlast[p]  = (n == row_len[r] - 1);
            s_axis_tuser[p]  = (row_bad[r] != 0) && (n == row_len[r] - 1);
            @(negedge clk);
            rdy = s_axis_tready[p];
            if (!rdy)
                ready_low = 1'b1;
            @(posedge clk);
            #drive_delay;
            if (rdy)
                n++;
        end
        s_axis_tvalid[p] = 1'b0;
        s_axis_tlast[p]  = 1'b0;
        s_axis_tuser[p]  = 1'b0;
        // Oversize frames are swallowed without back-pressure
        if (row_len[r] > fifo_depth && ready_low) begin
            $display("[FAIL] s_axis_tready[%0d] expected 0x1 actual 0x0", p);
            errors++;
        end
    endtask

    task automatic send_port_rows(input int t, input int p);
        for (int r = 0; r < row_count; r++) begin
            if (row_test[r] == t && row_port[r] == p)
                send_frame(r);
        end
    endtask

    // Compare one output beat with the head of its port's queue
    task automatic take_beat();
        int                    p;
        logic [data_width-1:0] exp_byte;
        logic                  exp_last;
        p = int'(m_axis_tid);
        if (!in_frame) begin
            in_frame = 1'b1;
            frame_id = p;
            beat_cnt = 0;
            cur_len  = 0;
            tid_order.push_back(p);
            if (exp_len[p].size() == 0) begin
                $display("An output frame on port %0d arrived with no frame expected", p);
                errors++;
            end else begin
                cur_len = exp_len[p].pop_front();
            end
        end else if (p != frame_id) begin
            $display("[FAIL] m_axis_tid expected 0x%h actual 0x%h", frame_id, p);
            errors++;
        end
        beat_cnt++;
        if (beat_cnt <= cur_len) begin
            exp_byte = exp_bytes[frame_id].pop_front();
            exp_last = (beat_cnt == cur_len);
            if (m_axis_tdata !== exp_byte) begin
                $display("[FAIL] m_axis_tdata expected 0x%h actual 0x%h", exp_byte, m_axis_tdata);
                errors++;
            end
            if (m_axis_tlast !== exp_last) begin
                $display("[FAIL] m_axis_tlast expected 0x%h actual 0x%h", exp_last, m_axis_tlast);
                errors++;
            end
        end else if (cur_len != 0) begin
            $display("An output frame on port %0d ran past its length of %0d", frame_id, cur_len);
            errors++;
        end
        if (m_axis_tlast) begin
            repeat (cur_len - beat_cnt) void'(exp_bytes[frame_id].pop_front());
            in_frame = 1'b0;
        end
    endtask

    task automatic check_status_counts();
        for (int p = 0; p < ports; p++) begin
            if (good_cnt[p] != exp_good[p]) begin
                $display("[FAIL] status_good_frame[%0d] pulses expected 0x%h actual 0x%h",
                         p, exp_good[p], good_cnt[p]);
                errors++;
            end
            if (bad_cnt[p] != exp_bad[p]) begin
                $display("[FAIL] status_bad_frame[%0d] pulses expected 0x%h actual 0x%h",
                         p, exp_bad[p], bad_cnt[p]);
                errors++;
            end
            if (ovf_cnt[p] != exp_ovf[p]) begin
                $display("[FAIL] status_overflow[%0d] pulses expected 0x%h actual 0x%h",
                         p, exp_ovf[p], ovf_cnt[p]);
                errors++;
            end
        end
    endtask

    // Dropped frames leave no stored words once every good frame is out
    task automatic check_drained();
        for (int p = 0; p < ports; p++) begin
            if (status_depth[p] !== '0) begin
                $display("[FAIL] status_depth[%0d] expected 0x00 actual 0x%h",
                         p, status_depth[p]);
                errors++;
            end
            if (status_depth_commit[p] !== '0) begin
                $display("[FAIL] status_depth_commit[%0d] expected 0x00 actual 0x%h",
                         p, status_depth_commit[p]);
                errors++;
            end
        end
    endtask

    function automatic bit port_order_matches();
        if (tid_order.size() != exp_order.size())
            return 1'b0;
        foreach (tid_order[i]) begin
            if (tid_order[i] != exp_order[i])
                return 1'b0;
        end
        return 1'b1;
    endfunction

    // Output and status monitor sampled mid-cycle where everything is settled
    always @(negedge clk) begin
        if (!reset) begin
            for (int p = 0; p < ports; p++) begin
                good_cnt[p] += int'(status_good_frame[p]);
                bad_cnt[p]  += int'(status_bad_frame[p]);
                ovf_cnt[p]  += int'(status_overflow[p]);
            end
            if (m_axis_tvalid && m_axis_tready)
                take_beat();
        end
    end

    always @(posedge clk) begin
        #drive_delay;
        if (out_mode == out_held)
            m_axis_tready = 1'b0;
        else if (out_mode == out_random)
            m_axis_tready = (($random(seed) & 3) != 0);
        else
            m_axis_tready = 1'b1;
    end

    always @(posedge clk) begin
        cycles++;
        if (timeout_limit != 0 && cycles > timeout_limit) begin
            $display("Timeout after %0d cycles, frames still expected: %0d on port 0, %0d on port 1",
                     cycles, exp_len[0].size(), exp_len[1].size());
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        int total_len;
        int errs_before;
        s_axis_tdata  = '0;
        s_axis_tvalid = '0;
        s_axis_tlast  = '0;
        s_axis_tuser  = '0;
        m_axis_tready = 1'b1;
        total_len = 0;

        test_name[1] = "good frame on port 0";
        test_name[2] = "bad frame dropped";
        test_name[3] = "oversize frame dropped";
        test_name[4] = "held output, port order";
        test_name[5] = "both ports, random back-pressure";
        add_row(1, 0, 5, 0, 'h10, out_open);
        add_row(2, 0, 7, 1, 'h20, out_open);
        add_row(2, 0, 4, 0, 'h30, out_open);
        add_row(3, 0, 40, 0, 'h40, out_open);
        add_row(3, 0, 3, 0, 'h70, out_open);
        add_row(4, 0, 6, 0, 'h80, out_held);
        add_row(4, 1, 6, 0, 'h90, out_held);
        add_row(5, 0, 9, 0, 'ha0, out_random);
        add_row(5, 1, 12, 0, 'hb0, out_random);
        add_row(5, 0, 5, 0, 'hc0, out_random);
        add_row(5, 1, 3, 0, 'hd0, out_random);
        add_row(5, 0, 8, 0, 'he0, out_random);
        add_row(5, 1, 10, 0, 'hf0, out_random);
        for (int r = 0; r < row_count; r++)
            total_len += row_len[r];
        timeout_limit = total_len * 4 + 500;

        @(posedge clk);
        while (reset) @(posedge clk);
        @(negedge clk);
        if (s_axis_tready !== 2'b11) begin
            $display("[FAIL] s_axis_tready expected 0x3 actual 0x%h after reset", s_axis_tready);
            errors++;
        end
        if (m_axis_tvalid !== 1'b0) begin
            $display("[FAIL] m_axis_tvalid expected 0x0 actual 0x%h after reset", m_axis_tvalid);
            errors++;
        end

        for (int t = 1; t <= num_tests; t++) begin
            errs_before = errors;
            exp_order.delete();
            tid_order.delete();
            for (int p = 0; p < ports; p++)
                held_words[p] = 0;
            @(negedge clk);
            for (int r = 0; r < row_count; r++) begin
                if (row_test[r] == t)
                    out_mode = row_mode[r];
            end
            @(posedge clk);
            #drive_delay;
            if (t == parallel_test) begin
                fork
                    send_port_rows(t, 0);
                    send_port_rows(t, 1);
                join
            end else begin
                for (int r = 0; r < row_count; r++) begin
                    if (row_test[r] == t)
                        send_frame(r);
                end
            end
            if (out_mode == out_held) begin
                @(posedge clk);
                @(negedge clk);
                for (int p = 0; p < ports; p++) begin
                    if (int'(status_depth_commit[p]) != held_words[p]) begin
                        $display("[FAIL] status_depth_commit[%0d] expected 0x%h actual 0x%h",
                                 p, held_words[p], status_depth_commit[p]);
                        errors++;
                    end
                    if (int'(status_depth[p]) != held_words[p]) begin
                        $display("[FAIL] status_depth[%0d] expected 0x%h actual 0x%h",
                                 p, held_words[p], status_depth[p]);
                        errors++;
                    end
                end
                out_mode = out_open;
            end
            while (exp_len[0].size() != 0 || exp_len[1].size() != 0 || in_frame)
                @(posedge clk);
            repeat (4) @(posedge clk);
            @(negedge clk);
            check_status_counts();
            check_drained();
            if (t == held_test && !port_order_matches()) begin
                $display("Frames left the output in the wrong port order");
                errors++;
            end
            if (errors == errs_before) begin
                pass_count++;
                $display("Test %0d (%s) passed", t, test_name[t]);
            end else begin
                fail_count++;
                $display("Test %0d (%s) failed with %0d errors", t, test_name[t],
                         errors - errs_before);
            end
        end

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
